/* build.f */
verilog/bt_pkg.sv
verilog/buf_port_if.sv
verilog/buffer_ram_arbiter.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/link_controller.sv
verilog/bt_bridge_top.sv
tests/clock_gen.sv
tests/bt_bridge_checker.sv
tests/bt_bridge_tb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, the result is taken from sim.log
cd "$(dirname "$0")" &&
rm -f sim.log &&
verilator --binary --timing --assert --top-module bt_bridge_tb -f build.f > sim.log 2>&1 &&
./obj_dir/Vbt_bridge_tb +verilator+error+limit+10 >> sim.log 2>&1
grep -q '^STATUS: PASS$' sim.log && echo "simulation passed" ||
	{ echo "simulation failed, see sim.log"; exit 1; }

/* tests/bt_bridge_checker.sv */
// Bound assertions on UART framing, rest gaps, controller state levels and read-back pulses
module bt_bridge_checker (
	input logic       clock_i,
	input logic       reset_i,
	input logic       txd_i,
	input logic [3:0] state_i,
	input logic       begin_i,
	input logic       done_i,
	input logic       host_word_valid_i,
	input logic       tx_start_i,
	input logic       tx_done_i
);
	// Raised by any failing assertion below
	logic       fail_seen = 1'b0;
	// Cycles into the current frame, zero between frames
	logic [7:0] frame_cyc;
	// High line cycles since the last frame ended
	logic [7:0] quiet;

	always_ff @(posedge clock_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			frame_cyc <= 8'd0;
			// No byte came before the first one
			quiet <= 8'hff;
		end
		else
		begin
			if (tx_start_i)
				frame_cyc <= 8'd1;
			else if (frame_cyc != 8'd0 && frame_cyc < 8'(10 * bt_pkg::BIT_CYCLES))
				frame_cyc <= frame_cyc + 8'd1;
			else
				frame_cyc <= 8'd0;
			if (frame_cyc != 8'd0 || !txd_i)
				quiet <= 8'd0;
			else if (quiet != 8'hff)
				quiet <= quiet + 8'd1;
		end
	end

	// Line rests high while nothing is sent
	a_idle_line: assert property (@(posedge clock_i) disable iff (reset_i)
		(state_i == bt_pkg::Idle || state_i == bt_pkg::Load ||
		state_i == bt_pkg::Wait_link) |-> txd_i)
		else
		begin
			fail_seen = 1'b1;
			$error("line low while no byte is being sent");
		end

	a_idle_hold: assert property (@(posedge clock_i) disable iff (reset_i)
		(state_i == bt_pkg::Idle || state_i == bt_pkg::Load) && !begin_i |=>
		(state_i == bt_pkg::Idle || state_i == bt_pkg::Load))
		else
		begin
			fail_seen = 1'b1;
			$error("controller left idle without begin");
		end

	a_start_bit: assert property (@(posedge clock_i) disable iff (reset_i)
		frame_cyc >= 8'd1 && frame_cyc <= 8'(bt_pkg::BIT_CYCLES) |-> !txd_i)
		else
		begin
			fail_seen = 1'b1;
			$error("start bit not low for a full bit time");
		end

	a_stop_bit: assert property (@(posedge clock_i) disable iff (reset_i)
		frame_cyc > 8'(9 * bt_pkg::BIT_CYCLES) |-> txd_i)
		else
		begin
			fail_seen = 1'b1;
			$error("stop bit not high for a full bit time");
		end

	// Done pulse closes the stop bit
	a_frame_end: assert property (@(posedge clock_i) disable iff (reset_i)
		frame_cyc == 8'(10 * bt_pkg::BIT_CYCLES) |-> tx_done_i)
		else
		begin
			fail_seen = 1'b1;
			$error("transmit done missing at end of frame");
		end

	a_gap: assert property (@(posedge clock_i) disable iff (reset_i)
		tx_start_i |-> quiet >= 8'(bt_pkg::GAP_CYCLES))
		else
		begin
			fail_seen = 1'b1;
			$error("rest gap between bytes too short");
		end

	a_done_hold: assert property (@(posedge clock_i) disable iff (reset_i)
		done_i && begin_i |=> done_i)
		else
		begin
			fail_seen = 1'b1;
			$error("done dropped while begin still high");
		end

	a_done_exit: assert property (@(posedge clock_i) disable iff (reset_i)
		done_i && !begin_i |=> state_i == bt_pkg::Idle)
		else
		begin
			fail_seen = 1'b1;
			$error("controller did not return to idle after begin fell");
		end

	a_valid_pulse: assert property (@(posedge clock_i) disable iff (reset_i)
		host_word_valid_i |-> (state_i == bt_pkg::Wait_host || state_i == bt_pkg::Done)
		##1 !host_word_valid_i)
		else
		begin
			fail_seen = 1'b1;
			$error("read-back valid not a single pulse after a read");
		end
endmodule

bind bt_bridge_top bt_bridge_checker chk0 (
	.clock_i           (clock),
	.reset_i           (reset),
	.txd_i             (txd_o),
	.state_i           (state_o),
	.begin_i           (begin_i),
	.done_i            (done_o),
	.host_word_valid_i (host_word_valid_o),
	.tx_start_i        (tx_start),
	.tx_done_i         (tx_done)
);

/* tests/bt_bridge_tb.sv */
// Testbench top with UART loopback, host load and read sequences, timeout and result messages
module bt_bridge_tb;
	logic        clock;
	logic        reset;
	logic [15:0] host_word;
	logic        host_load;
	logic        host_read;
	logic        begin_lvl;
	logic        at_mode;
	logic        bt_state;
	logic        txd_line;
	logic        loaded;
	logic [15:0] word_out;
	logic        word_valid;
	logic [3:0]  state;
	logic        done;
	integer      seed;
	int          cycles = 0;
	int          frames = 0;
	int          frame_left = 0;
	logic [15:0] words [$];

	clock_gen clk0 (
		.clock_o (clock)
	);

	// Transmit line looped straight back into the receiver
	bt_bridge_top dut0 (
		.clock             (clock),
		.reset             (reset),
		.host_word_i       (host_word),
		.host_load_i       (host_load),
		.host_read_i       (host_read),
		.begin_i           (begin_lvl),
		.at_mode_i         (at_mode),
		.bt_state_i        (bt_state),
		.rxd_i             (txd_line),
		.txd_o             (txd_line),
		.loaded_o          (loaded),
		.host_word_o       (word_out),
		.host_word_valid_o (word_valid),
		.state_o           (state),
		.done_o            (done)
	);

	// Limit is four runs of sixteen bytes with margin
	always @(posedge clock)
	begin
		cycles = cycles + 1;
		if (cycles > 4 * 16 * (10 * bt_pkg::BIT_CYCLES + bt_pkg::GAP_CYCLES + 20) * 2)
		begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped on timeout");
		end
	end

	always @(negedge clock)
	begin
		if (dut0.chk0.fail_seen)
		begin
			$display("an assertion bound to the DUT failed at time %0t", $time);
			$display("STATUS: FAIL");
			$fatal(1, "run stopped on assertion failure");
		end
	end

	// Counts start bits seen on the line, skipping the rest of each frame
	always @(negedge clock)
	begin
		if (reset)
			frame_left = 0;
		else if (frame_left > 0)
			frame_left = frame_left - 1;
		else if (!txd_line)
		begin
			frames = frames + 1;
			frame_left = 10 * bt_pkg::BIT_CYCLES - 1;
		end
	end

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
		input string what);
		if (got !== exp)
		begin
			$display("mismatch at %0t: %s got %0h expected %0h", $time, what, got, exp);
			$display("STATUS: FAIL");
			$fatal(1, "value check failed");
		end
	endtask

	task automatic step(input int n);
		repeat (n) @(negedge clock);
	endtask

	task automatic wait_state(input logic [3:0] code);
		while (state !== code)
			@(negedge clock);
	endtask

	task automatic pick_word(input logic zero_low, output logic [15:0] w);
		logic [7:0] lo;
		logic [7:0] hi;
		lo = 8'($random(seed));
		hi = 8'($random(seed));
		// A zero byte would end the message early
		if (lo == 8'h00)
			lo = 8'h3c;
		if (hi == 8'h00)
			hi = 8'hc3;
		if (zero_low)
			lo = 8'h00;
		w = {hi, lo};
	endtask

	task automatic load_word(input logic [15:0] w);
		host_word = w;
		host_load = 1'b1;
		@(negedge clock);
		host_load = 1'b0;
		while (!loaded)
			@(negedge clock);
	endtask

	task automatic load_words(input int n, input int zero_at);
		logic [15:0] w;
		words.delete();
		for (int i = 0; i < n; i++)
		begin
			pick_word(i == zero_at, w);
			load_word(w);
			words.push_back(w);
		end
	endtask

	task automatic read_word(input int k);
		wait_state(bt_pkg::Wait_host);
		host_read = 1'b1;
		@(negedge clock);
		host_read = 1'b0;
		while (!word_valid)
			@(negedge clock);
		check_value({16'h0, word_out}, {16'h0, words[k]}, "read-back word");
	endtask

	task automatic wait_done_no_response();
		while (!done)
		begin
			if (state == bt_pkg::Receive)
			begin
				$display("normal mode went into the response wait at time %0t", $time);
				$display("STATUS: FAIL");
				$fatal(1, "normal mode waited for a response");
			end
			@(negedge clock);
		end
	endtask

	task automatic end_run();
		wait_state(bt_pkg::Done);
		// Hold begin so done has to stay up
		step(10);
		begin_lvl = 1'b0;
		wait_state(bt_pkg::Idle);
		step(2);
	endtask

	initial
	begin
		int start_frames;
		seed = 74;
		reset = 1'b1;
		host_word = 16'h0000;
		host_load = 1'b0;
		host_read = 1'b0;
		begin_lvl = 1'b0;
		at_mode = 1'b0;
		bt_state = 1'b0;
		repeat (8) @(posedge clock);
		@(negedge clock);
		reset = 1'b0;
		step(4);

		// Command mode, two words echoed back and read as words
		at_mode = 1'b1;
		load_words(2, -1);
		start_frames = frames;
		begin_lvl = 1'b1;
		wait_state(bt_pkg::Wait_host);
		check_value(32'(frames - start_frames), 32'd4, "bytes sent in command mode");
		read_word(0);
		read_word(1);
		end_run();

		// Normal mode holds off until the link comes up
		at_mode = 1'b0;
		load_words(2, -1);
		start_frames = frames;
		begin_lvl = 1'b1;
		step(200);
		check_value({28'h0, state}, {28'h0, bt_pkg::Wait_link}, "state with link down");
		check_value(32'(frames - start_frames), 32'd0, "bytes sent with link down");
		bt_state = 1'b1;
		wait_done_no_response();
		check_value(32'(frames - start_frames), 32'd4, "bytes sent in normal mode");
		end_run();

		// Zero low byte in the second word stops the send there
		load_words(3, 1);
		start_frames = frames;
		begin_lvl = 1'b1;
		wait_done_no_response();
		check_value(32'(frames - start_frames), 32'd2, "bytes sent before zero byte");
		end_run();

		// Command mode with stray host strobes while sending
		at_mode = 1'b1;
		bt_state = 1'b0;
		load_words(3, -1);
		start_frames = frames;
		begin_lvl = 1'b1;
		wait_state(bt_pkg::Send);
		host_read = 1'b1;
		host_load = 1'b1;
		step(1);
		host_read = 1'b0;
		host_load = 1'b0;
		wait_state(bt_pkg::Wait_host);
		check_value(32'(frames - start_frames), 32'd6, "bytes sent with stray strobes");
		read_word(0);
		read_word(1);
		end_run();

		if (dut0.chk0.fail_seen)
		begin
			$display("STATUS: FAIL");
			$fatal(1, "assertion failure seen at end of run");
		end
		else
		begin
			$display("STATUS: PASS");
			$finish;
		end
	end
endmodule

/* tests/clock_gen.sv */
// Testbench clock source with a period of 20 time units
module clock_gen (
	output logic clock_o
);
	initial
	begin
		clock_o = 1'b0;
		forever
			#10 clock_o = ~clock_o;
	end
endmodule

/* verilog/bt_bridge_top.sv */
// Serial link bridge top level joining buffer arbiter, UART pair and link controller
module bt_bridge_top (
	input  logic        clock,
	input  logic        reset,
	input  logic [15:0] host_word_i,
	input  logic        host_load_i,
	input  logic        host_read_i,
	input  logic        begin_i,
	input  logic        at_mode_i,
	input  logic        bt_state_i,
	input  logic        rxd_i,
	output logic        txd_o,
	output logic        loaded_o,
	output logic [15:0] host_word_o,
	output logic        host_word_valid_o,
	output logic [3:0]  state_o,
	output logic        done_o
);
	logic       tx_start;
	logic [7:0] tx_data;
	logic       tx_done;
	logic [4:0] rx_count;
	logic       rx_clear;

	// One buffer port per requester
	buf_port_if rx_bus ();
	buf_port_if ctl_bus ();

	buffer_ram_arbiter arb0 (
		.clock_i  (clock),
		.reset_i  (reset),
		.rx_port  (rx_bus.arbiter),
		.ctl_port (ctl_bus.arbiter)
	);

	uart_tx tx0 (
		.clock_i (clock),
		.reset_i (reset),
		.start_i (tx_start),
		.data_i  (tx_data),
		.txd_o   (txd_o),
		.done_o  (tx_done)
	);

	uart_rx rx0 (
		.clock_i  (clock),
		.reset_i  (reset),
		.rxd_i    (rxd_i),
		.clear_i  (rx_clear),
		.buf_port (rx_bus.requester),
		.count_o  (rx_count)
	);

	link_controller ctl0 (
		.clock_i           (clock),
		.reset_i           (reset),
		.host_word_i       (host_word_i),
		.host_load_i       (host_load_i),
		.host_read_i       (host_read_i),
		.begin_i           (begin_i),
		.at_mode_i         (at_mode_i),
		.bt_state_i        (bt_state_i),
		.host_word_o       (host_word_o),
		.host_word_valid_o (host_word_valid_o),
		.loaded_o          (loaded_o),
		.state_o           (state_o),
		.done_o            (done_o),
		.rx_count_i        (rx_count),
		.rx_clear_o        (rx_clear),
		.tx_start_o        (tx_start),
		.tx_data_o         (tx_data),
		.tx_done_i         (tx_done),
		.buf_port          (ctl_bus.requester)
	);
endmodule

/* verilog/bt_pkg.sv */
// Buffer geometry, UART timing and link controller state codes
package bt_pkg;
	// Byte buffer split into a transmit region and a receive region
	localparam int unsigned BUF_DEPTH = 32;
	localparam int unsigned ADDR_W = 5;
	localparam logic [ADDR_W-1:0] TX_BASE = 5'd0;
	localparam logic [ADDR_W-1:0] RX_BASE = 5'd16;
	localparam logic [ADDR_W-1:0] REGION_BYTES = 5'd16;

	// UART bit timing, short for simulation
	localparam int unsigned BIT_CYCLES = 8;
	localparam int unsigned BIT_CNT_W = $clog2(BIT_CYCLES);
	localparam int unsigned MID_BIT = BIT_CYCLES / 2 - 1;

	// Idle time on the line after each sent byte
	localparam int unsigned GAP_CYCLES = 40;
	localparam int unsigned GAP_CNT_W = $clog2(GAP_CYCLES);

	// Bytes expected back from the module in command mode
	localparam logic [ADDR_W-1:0] RESP_BYTES = 5'd4;

	localparam logic [3:0] Idle = 4'd0;
	localparam logic [3:0] Load = 4'd1;
	localparam logic [3:0] Wait_link = 4'd2;
	localparam logic [3:0] Fetch = 4'd3;
	localparam logic [3:0] Send = 4'd4;
	localparam logic [3:0] Rest = 4'd5;
	localparam logic [3:0] Receive = 4'd6;
	localparam logic [3:0] Wait_host = 4'd7;
	localparam logic [3:0] Read = 4'd8;
	localparam logic [3:0] Done = 4'd15;
endpackage

/* verilog/buf_port_if.sv */
// Buffer access port with requester and arbiter views
interface buf_port_if;
	// Request fields are held by the requester until gnt
	logic                      req;
	logic                      gnt;
	logic                      we;
	logic [bt_pkg::ADDR_W-1:0] addr;
	logic [7:0]                wdata;
	// Valid on the cycle after gnt for a read
	logic [7:0]                rdata;

	modport requester (
		output req, we, addr, wdata,
		input  gnt, rdata
	);

	modport arbiter (
		input  req, we, addr, wdata,
		output gnt, rdata
	);
endinterface

/* verilog/buffer_ram_arbiter.sv */
// Shared byte RAM with fixed-priority arbitration between receiver and controller ports
module buffer_ram_arbiter (
	input  logic     clock_i,
	input  logic     reset_i,
	buf_port_if.arbiter rx_port,
	buf_port_if.arbiter ctl_port
);
	logic [7:0] mem [bt_pkg::BUF_DEPTH];
	logic [7:0] rx_rdata;
	logic [7:0] ctl_rdata;
	logic                      acc_en;
	logic                      acc_we;
	logic [bt_pkg::ADDR_W-1:0] acc_addr;
	logic [7:0]                acc_wdata;

	// Receiver always wins, it asks for one cycle per byte at most
	assign rx_port.gnt = rx_port.req;
	assign ctl_port.gnt = ctl_port.req && !rx_port.req;

	assign acc_en = rx_port.gnt || ctl_port.gnt;
	assign acc_we = rx_port.gnt ? rx_port.we : ctl_port.we;
	assign acc_addr = rx_port.gnt ? rx_port.addr : ctl_port.addr;
	assign acc_wdata = rx_port.gnt ? rx_port.wdata : ctl_port.wdata;

	assign rx_port.rdata = rx_rdata;
	assign ctl_port.rdata = ctl_rdata;

	always_ff @(posedge clock_i)
	begin
		if (acc_en && acc_we)
			mem[acc_addr] <= acc_wdata;
	end

	// Read data lands in the port that was granted
	always_ff @(posedge clock_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			rx_rdata <= 8'h00;
			ctl_rdata <= 8'h00;
		end
		else
		begin
			if (rx_port.gnt && !rx_port.we)
				rx_rdata <= mem[rx_port.addr];
			if (ctl_port.gnt && !ctl_port.we)
				ctl_rdata <= mem[ctl_port.addr];
		end
	end
endmodule

/* verilog/link_controller.sv */
// Link controller FSM for host load, byte send, rest gap, response wait and host read
module link_controller (
	input  logic        clock_i,
	input  logic        reset_i,
	input  logic [15:0] host_word_i,
	input  logic        host_load_i,
	input  logic        host_read_i,
	input  logic        begin_i,
	input  logic        at_mode_i,
	input  logic        bt_state_i,
	output logic [15:0] host_word_o,
	output logic        host_word_valid_o,
	output logic        loaded_o,
	output logic [3:0]  state_o,
	output logic        done_o,
	input  logic [4:0]  rx_count_i,
	output logic        rx_clear_o,
	output logic        tx_start_o,
	output logic [7:0]  tx_data_o,
	input  logic        tx_done_i,
	buf_port_if.requester buf_port
);
	logic [3:0]                   state;
	logic [3:0]                   end_state;
	logic                         req;
	logic                         we;
	logic                         pend;
	logic                         hi;
	logic                         cmd_mode;
	logic                         load_ok;
	logic [bt_pkg::ADDR_W-1:0]    addr;
	logic [bt_pkg::ADDR_W-1:0]    load_bytes;
	logic [bt_pkg::ADDR_W-1:0]    send_idx;
	logic [bt_pkg::ADDR_W-1:0]    rd_idx;
	logic [7:0]                   wdata;
	logic [15:0]                  word_hold;
	logic [bt_pkg::GAP_CNT_W-1:0] gap_cnt;

	assign buf_port.req = req;
	assign buf_port.we = we;
	assign buf_port.addr = addr;
	assign buf_port.wdata = wdata;
	assign state_o = state;
	assign done_o = (state == bt_pkg::Done);
	assign end_state = cmd_mode ? bt_pkg::Receive : bt_pkg::Done;

	// First load out of Idle restarts both regions
	assign load_ok = host_load_i && !req && ((state == bt_pkg::Idle) ||
		(state == bt_pkg::Load && load_bytes < bt_pkg::REGION_BYTES));
	assign rx_clear_o = load_ok && (state == bt_pkg::Idle);

	always_ff @(posedge clock_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			state <= bt_pkg::Idle;
			req <= 1'b0;
			we <= 1'b0;
			pend <= 1'b0;
			hi <= 1'b0;
			cmd_mode <= 1'b0;
			addr <= '0;
			load_bytes <= '0;
			send_idx <= '0;
			rd_idx <= '0;
			wdata <= 8'h00;
			word_hold <= 16'h0000;
			gap_cnt <= '0;
			tx_start_o <= 1'b0;
			tx_data_o <= 8'h00;
			loaded_o <= 1'b0;
			host_word_o <= 16'h0000;
			host_word_valid_o <= 1'b0;
		end
		else
		begin
			tx_start_o <= 1'b0;
			loaded_o <= 1'b0;
			host_word_valid_o <= 1'b0;
			// Read data follows a granted read by one cycle
			pend <= req && buf_port.gnt && !we;
			if (buf_port.gnt)
				req <= 1'b0;
			case (state)
				bt_pkg::Idle, bt_pkg::Load:
				begin
					if (req && we && buf_port.gnt)
					begin
						load_bytes <= load_bytes + 5'd1;
						if (!hi)
						begin
							hi <= 1'b1;
							req <= 1'b1;
							addr <= addr + 5'd1;
							wdata <= word_hold[15:8];
						end
						else
						begin
							hi <= 1'b0;
							loaded_o <= 1'b1;
						end
					end
					else if (load_ok)
					begin
						word_hold <= host_word_i;
						req <= 1'b1;
						we <= 1'b1;
						wdata <= host_word_i[7:0];
						state <= bt_pkg::Load;
						if (state == bt_pkg::Idle)
						begin
							load_bytes <= '0;
							addr <= bt_pkg::TX_BASE;
						end
						else
							addr <= bt_pkg::TX_BASE + load_bytes;
					end
					else if (begin_i && !req)
					begin
						cmd_mode <= at_mode_i;
						send_idx <= '0;
						// Command mode talks to the module without a link
						state <= at_mode_i ? bt_pkg::Fetch : bt_pkg::Wait_link;
					end
				end
				bt_pkg::Wait_link:
				begin
					if (bt_state_i)
						state <= bt_pkg::Fetch;
				end
				bt_pkg::Fetch:
				begin
					if (pend)
					begin
						// A zero byte ends the message
						if (buf_port.rdata == 8'h00)
							state <= end_state;
						else
						begin
							tx_data_o <= buf_port.rdata;
							tx_start_o <= 1'b1;
							state <= bt_pkg::Send;
						end
					end
					else if (!req)
					begin
						if (send_idx == load_bytes)
							state <= end_state;
						else
						begin
							req <= 1'b1;
							we <= 1'b0;
							addr <= bt_pkg::TX_BASE + send_idx;
						end
					end
				end
				bt_pkg::Send:
				begin
					if (tx_done_i)
					begin
						gap_cnt <= '0;
						send_idx <= send_idx + 5'd1;
						state <= bt_pkg::Rest;
					end
				end
				bt_pkg::Rest:
				begin
					if (gap_cnt == bt_pkg::GAP_CNT_W'(bt_pkg::GAP_CYCLES - 1))
						state <= bt_pkg::Fetch;
					else
						gap_cnt <= gap_cnt + 1'b1;
				end
				bt_pkg::Receive:
				begin
					if (rx_count_i >= bt_pkg::RESP_BYTES)
					begin
						rd_idx <= '0;
						state <= bt_pkg::Wait_host;
					end
				end
				bt_pkg::Wait_host:
				begin
					if (!begin_i)
						state <= bt_pkg::Done;
					else if (host_read_i)
					begin
						hi <= 1'b0;
						req <= 1'b1;
						we <= 1'b0;
						addr <= bt_pkg::RX_BASE + rd_idx;
						state <= bt_pkg::Read;
					end
				end
				bt_pkg::Read:
				begin
					if (pend && !hi)
					begin
						word_hold[7:0] <= buf_port.rdata;
						hi <= 1'b1;
						req <= 1'b1;
						addr <= addr + 5'd1;
					end
					else if (pend)
					begin
						host_word_o <= {buf_port.rdata, word_hold[7:0]};
						host_word_valid_o <= 1'b1;
						hi <= 1'b0;
						rd_idx <= rd_idx + 5'd2;
						// Whole response handed over
						if (rd_idx + 5'd2 >= bt_pkg::RESP_BYTES)
							state <= bt_pkg::Done;
						else
							state <= bt_pkg::Wait_host;
					end
				end
				bt_pkg::Done:
				begin
					if (!begin_i)
						state <= bt_pkg::Idle;
				end
				default:
					state <= bt_pkg::Idle;
			endcase
		end
	end
endmodule

/* verilog/uart_rx.sv */
// UART receiver, 8N1, writes each good byte into the receive region of the buffer
module uart_rx (
	input  logic       clock_i,
	input  logic       reset_i,
	input  logic       rxd_i,
	input  logic       clear_i,
	buf_port_if.requester buf_port,
	output logic [4:0] count_o
);
	logic                         rxd_sync;
	logic                         active;
	logic [bt_pkg::BIT_CNT_W-1:0] cyc_cnt;
	logic [3:0]                   bit_cnt;
	logic [7:0]                   shift;
	logic [4:0]                   count;
	logic                         req;
	logic [bt_pkg::ADDR_W-1:0]    addr;
	logic [7:0]                   wdata;
	logic                         mid;
	logic                         bit_end;

	assign mid = (cyc_cnt == bt_pkg::BIT_CNT_W'(bt_pkg::MID_BIT));
	assign bit_end = (cyc_cnt == bt_pkg::BIT_CNT_W'(bt_pkg::BIT_CYCLES - 1));

	assign buf_port.req = req;
	assign buf_port.we = 1'b1;
	assign buf_port.addr = addr;
	assign buf_port.wdata = wdata;
	assign count_o = count;

	always_ff @(posedge clock_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			rxd_sync <= 1'b1;
			active <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= 4'd0;
			shift <= 8'h00;
			count <= 5'd0;
			req <= 1'b0;
			addr <= bt_pkg::RX_BASE;
			wdata <= 8'h00;
		end
		else
		begin
			rxd_sync <= rxd_i;
			if (buf_port.gnt)
				req <= 1'b0;
			if (!active)
			begin
				if (!rxd_sync)
				begin
					active <= 1'b1;
					cyc_cnt <= '0;
					bit_cnt <= 4'd0;
				end
			end
			else
			begin
				cyc_cnt <= bit_end ? '0 : cyc_cnt + 1'b1;
				if (bit_end)
					bit_cnt <= bit_cnt + 4'd1;
				if (mid)
				begin
					// Start bit gone high again means a glitch
					if (bit_cnt == 4'd0)
						active <= !rxd_sync;
					else if (bit_cnt == 4'd9)
					begin
						active <= 1'b0;
						// Bad stop bit drops the byte
						if (rxd_sync)
						begin
							req <= 1'b1;
							addr <= bt_pkg::RX_BASE + {1'b0, count[3:0]};
							wdata <= shift;
							count <= count + 5'd1;
						end
					end
					else
						shift <= {rxd_sync, shift[7:1]};
				end
			end
			if (clear_i)
				count <= 5'd0;
		end
	end
endmodule

/* verilog/uart_tx.sv */
// UART transmitter, 8N1, LSB first, start strobe in and done pulse out
module uart_tx (
	input  logic       clock_i,
	input  logic       reset_i,
	input  logic       start_i,
	input  logic [7:0] data_i,
	output logic       txd_o,
	output logic       done_o
);
	logic                         busy;
	logic [bt_pkg::BIT_CNT_W-1:0] cyc_cnt;
	logic [3:0]                   bit_cnt;
	logic [7:0]                   shift;
	logic                         bit_end;

	assign bit_end = (cyc_cnt == bt_pkg::BIT_CNT_W'(bt_pkg::BIT_CYCLES - 1));

	// Pulses on the last cycle of the stop bit 10 bit times after the start strobe
	assign done_o = busy && bit_end && (bit_cnt == 4'd9);

	always_ff @(posedge clock_i or posedge reset_i)
	begin
		if (reset_i)
		begin
			busy <= 1'b0;
			cyc_cnt <= '0;
			bit_cnt <= 4'd0;
			shift <= '1;
			txd_o <= 1'b1;
		end
		else if (!busy)
		begin
			if (start_i)
			begin
				busy <= 1'b1;
				cyc_cnt <= '0;
				bit_cnt <= 4'd0;
				shift <= data_i;
				txd_o <= 1'b0;
			end
		end
		else if (bit_end)
		begin
			cyc_cnt <= '0;
			if (bit_cnt == 4'd9)
				busy <= 1'b0;
			else
			begin
				bit_cnt <= bit_cnt + 4'd1;
				txd_o <= shift[0];
				// Ones fill in behind the data and form the stop bit
				shift <= {1'b1, shift[7:1]};
			end
		end
		else
			cyc_cnt <= cyc_cnt + 1'b1;
	end
endmodule
